//--- list.f
hdl/clocking_pkg.sv
hdl/synchronizer.sv
hdl/pps_capture_select.sv
hdl/lock_filter.sv
hdl/pps_timekeeper.sv
hdl/e320_clocking.sv
dv/clocking_checker.sv
dv/tb_e320_clocking.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the e320 clocking testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f list.f \
  --top-module tb_e320_clocking \
  -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if grep -qF "*** TEST PASSED ***" <<< "$out"; then
  exit 0
else
  exit 1
fi

//--- dv/clocking_stimulus.txt
# Columns: name op sel src len_a len_b expected
# pps: sel, src 0 ext 1 gps, len_a gap in ref_clk cycles, len_b pulses, expected seconds gained
# lock: len_a cycles locked_raw high then len_b cycles low, expected clocks_locked at end
# reset: len_a cycles of global_rst, expected seconds afterwards
# A length of -1 is picked at random
int_sel_ext_only   pps   1 0 50 3 0
int_sel_gps        pps   1 1 60 4 4
ext_sel_ext        pps   2 0 55 3 3
ext_sel_gps        pps   2 1 50 3 0
zero_sel_gps       pps   0 1 70 3 3
zero_sel_ext       pps   0 0 50 2 0
both_sel_gps       pps   3 1 45 3 3
both_sel_ext       pps   3 0 45 2 0
random_gap_gps     pps   1 1 -1 4 4
random_gap_ext     pps   2 0 -1 3 3
lock_full_hold     lock  0 0 1100 0 1
lock_dropout       lock  0 0 0 12 0
lock_glitch        lock  0 0 500 4 0
lock_random_glitch lock  0 0 700 -1 0
lock_short_hold    lock  0 0 1020 0 0
lock_hold_done     lock  0 0 10 0 1
mid_run_reset      reset 0 0 4 0 0
lock_after_reset   lock  0 0 1100 0 1
gps_after_reset    pps   0 1 40 3 3

//--- dv/tb_e320_clocking.sv
`timescale 1ns/100ps

module tb_e320_clocking import clocking_pkg::*; ();

  logic                     clk156 = 1'b0;
  logic                     ref_clk_from_pin = 1'b0;
  logic                     global_rst;
  logic                     locked_raw;
  logic                     ext_pps_from_pin;
  logic                     gps_pps_from_pin;
  logic [pps_sel_width-1:0] pps_select;
  logic                     ref_clk;
  logic                     ddr3_dma_clk;
  logic                     clocks_locked;
  logic                     pps_refclk;
  logic                     pps_seen;
  logic [sec_width-1:0]     seconds;
  logic [tick_width-1:0]    last_pps_ticks;

  // Test state shared with the checker
  logic [191:0]          cur_name = '0;
  int                    test_id = 0;
  logic [1:0]            check_kind = 2'd0;
  logic                  check_req = 1'b0;
  int                    exp_value = 0;
  logic [tick_width-1:0] exp_ticks = '0;
  int                    value_errors;
  int                    other_errors;

  // Stimulus table with one entry per file line
  logic [191:0] name_q[$];
  logic [191:0] op_q[$];
  int sel_q[$];
  int src_q[$];
  int len_a_q[$];
  int len_b_q[$];
  int exp_q[$];

  int tb_errors = 0;
  int cycle_count = 0;
  int cycle_limit = 32'h7fffffff;
  logic [31:0] rng_state = 32'd18;

  // 20 ns system clock and 25 ns reference clock
  always #10 clk156 = ~clk156;
  always #12.5 ref_clk_from_pin = ~ref_clk_from_pin;

  e320_clocking i_dut (
    .global_rst       (global_rst),
    .ref_clk_from_pin (ref_clk_from_pin),
    .ref_clk          (ref_clk),
    .clk156           (clk156),
    .ddr3_dma_clk_in  (clk156),
    .ddr3_dma_clk     (ddr3_dma_clk),
    .locked_raw       (locked_raw),
    .clocks_locked    (clocks_locked),
    .ext_pps_from_pin (ext_pps_from_pin),
    .gps_pps_from_pin (gps_pps_from_pin),
    .pps_select       (pps_select),
    .pps_refclk       (pps_refclk),
    .seconds          (seconds),
    .last_pps_ticks   (last_pps_ticks),
    .pps_seen         (pps_seen)
  );

  clocking_checker i_checker (
    .clk156           (clk156),
    .ref_clk_from_pin (ref_clk_from_pin),
    .ref_clk          (ref_clk),
    .ddr3_dma_clk     (ddr3_dma_clk),
    .global_rst       (global_rst),
    .locked_raw       (locked_raw),
    .clocks_locked    (clocks_locked),
    .pps_refclk       (pps_refclk),
    .seconds          (seconds),
    .last_pps_ticks   (last_pps_ticks),
    .pps_seen         (pps_seen),
    .test_name        (cur_name),
    .test_id          (test_id),
    .check_kind       (check_kind),
    .check_req        (check_req),
    .exp_value        (exp_value),
    .exp_ticks        (exp_ticks),
    .value_errors     (value_errors),
    .other_errors     (other_errors)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reads the table, resolves random lengths and sets the timeout
  task automatic load_stimulus();
    int fd;
    int fields;
    string line;
    logic [191:0] name;
    logic [191:0] op;
    int sel;
    int src;
    int len_a;
    int len_b;
    int exp_v;
    int ref_sum;
    int clk_sum;
    ref_sum = 0;
    clk_sum = 0;
    fd = $fopen("dv/clocking_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file dv/clocking_stimulus.txt");
      tb_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != 8'h23) begin
        fields = $sscanf(line, "%s %s %d %d %d %d %d", name, op, sel, src, len_a, len_b, exp_v);
        if (fields == 7) begin
          if (op == "pps" && len_a < 0) begin
            rng_state = xorshift(rng_state);
            len_a = 40 + int'(rng_state % 32'd64);
          end
          if (op == "lock" && len_b < 0) begin
            rng_state = xorshift(rng_state);
            len_b = 1 + int'(rng_state % 32'd8);
          end
          // Gaps and holds plus the quiet cycles each test adds
          if (op == "pps") begin
            ref_sum += len_a * len_b + 20;
          end else begin
            clk_sum += len_a + len_b + 2;
          end
          name_q.push_back(name);
          op_q.push_back(op);
          sel_q.push_back(sel);
          src_q.push_back(src);
          len_a_q.push_back(len_a);
          len_b_q.push_back(len_b);
          exp_q.push_back(exp_v);
        end
      end
    end
    $fclose(fd);
    cycle_limit = clk_sum + (ref_sum * 25 + 19) / 20 + 200;
  endtask

  task automatic set_pin(input int src, input logic level);
    if (src == 0) begin
      ext_pps_from_pin = level;
    end else begin
      gps_pps_from_pin = level;
    end
  endtask

  // Rising edges on the pin are exactly gap ref_clk cycles apart
  task automatic run_pps(input int sel, input int src, input int gap, input int count);
    @(posedge ref_clk);
    #2;
    pps_select = pps_sel_width'(sel);
    exp_ticks = tick_width'(gap);
    // Quiet cycles so the select settles before counting starts
    repeat (8) @(posedge ref_clk);
    test_id++;
    for (int n = 0; n < count; n++) begin
      @(posedge ref_clk);
      #2;
      set_pin(src, 1'b1);
      repeat (3) @(posedge ref_clk);
      #2;
      set_pin(src, 1'b0);
      repeat (gap - 4) @(posedge ref_clk);
    end
    repeat (10) @(posedge ref_clk);
  endtask

  task automatic run_lock(input int high_cycles, input int low_cycles);
    if (high_cycles > 0) begin
      @(posedge clk156);
      #2;
      locked_raw = 1'b1;
      repeat (high_cycles) @(posedge clk156);
    end
    if (low_cycles > 0) begin
      if (high_cycles == 0) begin
        @(posedge clk156);
      end
      #2;
      locked_raw = 1'b0;
      repeat (low_cycles) @(posedge clk156);
    end
    #2;
  endtask

  task automatic run_reset(input int cycles);
    @(posedge clk156);
    #2;
    global_rst = 1'b1;
    repeat (cycles) @(posedge clk156);
    #2;
    global_rst = 1'b0;
  endtask

  task automatic request_check(input logic [1:0] kind, input int value);
    check_kind = kind;
    exp_value = value;
    check_req = 1'b1;
    #1;
    check_req = 1'b0;
  endtask

  // Run length guard
  always @(posedge clk156) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d clk156 cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    global_rst = 1'b1;
    locked_raw = 1'b0;
    ext_pps_from_pin = 1'b0;
    gps_pps_from_pin = 1'b0;
    pps_select = '0;
    load_stimulus();
    repeat (4) @(posedge clk156);
    #2;
    global_rst = 1'b0;

    for (int i = 0; i < name_q.size(); i++) begin
      cur_name = name_q[i];
      if (op_q[i] == "pps") begin
        run_pps(sel_q[i], src_q[i], len_a_q[i], len_b_q[i]);
        request_check(2'd0, exp_q[i]);
      end else if (op_q[i] == "lock") begin
        run_lock(len_a_q[i], len_b_q[i]);
        request_check(2'd1, exp_q[i]);
      end else if (op_q[i] == "reset") begin
        run_reset(len_a_q[i]);
        request_check(2'd2, exp_q[i]);
      end else begin
        $display("unknown operation in the stimulus file for %0s", cur_name);
        tb_errors++;
      end
    end

    repeat (10) @(posedge clk156);
    $display("errors: %0d value, %0d other, %0d testbench",
             value_errors, other_errors, tb_errors);
    if (value_errors + other_errors + tb_errors == 0 && name_q.size() > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- dv/clocking_checker.sv
`timescale 1ns/100ps

module clocking_checker import clocking_pkg::*; (
  input  logic                  clk156,
  input  logic                  ref_clk_from_pin,
  input  logic                  ref_clk,
  input  logic                  ddr3_dma_clk,
  input  logic                  global_rst,
  input  logic                  locked_raw,
  input  logic                  clocks_locked,
  input  logic                  pps_refclk,
  input  logic [sec_width-1:0]  seconds,
  input  logic [tick_width-1:0] last_pps_ticks,
  input  logic                  pps_seen,
  // Current test from the testbench
  input  logic [191:0]          test_name,
  input  int                    test_id,
  input  logic [1:0]            check_kind,
  input  logic                  check_req,
  input  int                    exp_value,
  input  logic [tick_width-1:0] exp_ticks,
  output int                    value_errors,
  output int                    other_errors
);

  // Locked after edge k needs the samples of edges k-1025 .. k-2 all high
  localparam int lock_target = lock_hold_cycles + 1;

  int lock_errs = 0;
  int tick_errs = 0;
  int end_errs = 0;
  int rst_errs = 0;
  int clk_errs = 0;
  int seen_errs = 0;

  // Run lengths of high locked_raw samples now and delayed by the sync stages
  int run_now = 0;
  int run_d1 = 0;
  int run_d2 = 0;
  logic lock_exp;

  int last_id = -1;
  int pulse_count = 0;
  logic seen_d = 1'b0;
  logic [sec_width-1:0] sec_base = '0;

  assign value_errors = lock_errs + tick_errs + end_errs + rst_errs + clk_errs;
  assign other_errors = seen_errs;

  // ----------------------------------------
  // Lock timing on every clk156 cycle
  // ----------------------------------------

  // Outputs settled mid cycle
  // locked_raw already holds the next sample
  always @(negedge clk156) begin
    if (global_rst) begin
      run_now = 0;
      run_d1 = 0;
      run_d2 = 0;
    end else begin
      lock_exp = (run_d2 >= lock_target);
      if (clocks_locked !== lock_exp) begin
        lock_errs++;
        $display("error: %0s clocks_locked expected %0d actual %0d",
                 test_name, lock_exp, clocks_locked);
      end
      run_d2 = run_d1;
      run_d1 = run_now;
      run_now = locked_raw ? run_now + 1 : 0;
    end
  end

  // ----------------------------------------
  // PPS pulses and spacing
  // ----------------------------------------

  always @(negedge ref_clk) begin
    if (global_rst) begin
      seen_d = 1'b0;
    end else begin
      // New test takes a fresh seconds baseline
      if (test_id != last_id) begin
        last_id = test_id;
        sec_base = seconds;
        pulse_count = 0;
      end
      if (pps_seen) begin
        if (seen_d) begin
          seen_errs++;
          $display("%0s: pps_seen stayed high for more than one cycle", test_name);
        end else begin
          pulse_count++;
          // First pulse of a test follows an unrelated gap
          if (pulse_count > 1 && exp_ticks != '0 && last_pps_ticks !== exp_ticks) begin
            tick_errs++;
            $display("error: %0s last_pps_ticks expected %0d actual %0d",
                     test_name, exp_ticks, last_pps_ticks);
          end
        end
      end
      seen_d = pps_seen;
    end
  end

  // ----------------------------------------
  // Clock passthroughs
  // ----------------------------------------

  // Each output is compared with its source just after every transition
  always @(clk156) begin
    #1;
    if (ddr3_dma_clk !== clk156) begin
      clk_errs++;
      $display("error: %0s ddr3_dma_clk expected %0b actual %0b",
               test_name, clk156, ddr3_dma_clk);
    end
  end

  always @(ref_clk_from_pin) begin
    #1;
    if (ref_clk !== ref_clk_from_pin) begin
      clk_errs++;
      $display("error: %0s ref_clk expected %0b actual %0b",
               test_name, ref_clk_from_pin, ref_clk);
    end
  end

  // ----------------------------------------
  // End of test results
  // ----------------------------------------

  always @(posedge check_req) begin
    case (check_kind)
      2'd0: begin
        if (seconds - sec_base !== sec_width'(exp_value)) begin
          end_errs++;
          $display("error: %0s seconds gained expected %0d actual %0d",
                   test_name, exp_value, seconds - sec_base);
        end
        if (pulse_count != exp_value) begin
          end_errs++;
          $display("error: %0s pps_seen pulses expected %0d actual %0d",
                   test_name, exp_value, pulse_count);
        end
      end
      2'd1: begin
        if (clocks_locked !== exp_value[0]) begin
          end_errs++;
          $display("error: %0s clocks_locked expected %0d actual %0d",
                   test_name, exp_value, clocks_locked);
        end
      end
      default: begin
        if (seconds !== sec_width'(exp_value)) begin
          end_errs++;
          $display("error: %0s seconds expected %0d actual %0d",
                   test_name, exp_value, seconds);
        end
      end
    endcase
  end

  // Reset clears the outputs without waiting for a clock
  always @(posedge global_rst) begin
    #1;
    if (clocks_locked !== 1'b0 || pps_refclk !== 1'b0 || seconds !== '0) begin
      rst_errs++;
      $display("error: %0s reset outputs expected 0 0 0 actual %0d %0d %0d",
               test_name, clocks_locked, pps_refclk, seconds);
    end
  end

endmodule

//--- hdl/e320_clocking.sv
`timescale 1ns/100ps

module e320_clocking import clocking_pkg::*; (
  input  logic                     global_rst,

  // Reference clock
  input  logic                     ref_clk_from_pin,
  output logic                     ref_clk,

  // 156.25 MHz system clock
  input  logic                     clk156,

  // 300 MHz DMA clock, made outside the model
  input  logic                     ddr3_dma_clk_in,
  output logic                     ddr3_dma_clk,

  // Synthesizer lock
  input  logic                     locked_raw,
  output logic                     clocks_locked,

  // PPS capture and selection
  input  logic                     ext_pps_from_pin,
  input  logic                     gps_pps_from_pin,
  input  logic [pps_sel_width-1:0] pps_select,
  output logic                     pps_refclk,

  // Timekeeping
  output logic [sec_width-1:0]     seconds,
  output logic [tick_width-1:0]    last_pps_ticks,
  output logic                     pps_seen
);

  // ----------------------------------------
  // Clock passthroughs
  // ----------------------------------------

  // Stands in for the input buffer and global buffer on the reference pin
  assign ref_clk = ref_clk_from_pin;

  // Stands in for the clock manager output and its global buffer
  assign ddr3_dma_clk = ddr3_dma_clk_in;

  // ----------------------------------------
  // PPS capture, ref_clk domain
  // ----------------------------------------

  // Both pins and the select cross into ref_clk here
  pps_capture_select pps_capture (
    .ref_clk          (ref_clk),
    .global_rst       (global_rst),
    .ext_pps_from_pin (ext_pps_from_pin),
    .gps_pps_from_pin (gps_pps_from_pin),
    .pps_select       (pps_select),
    .pps_refclk       (pps_refclk)
  );

  // ----------------------------------------
  // Timekeeper, ref_clk domain
  // ----------------------------------------

  // Counts seconds off the selected pulse
  pps_timekeeper timekeeper (
    .ref_clk        (ref_clk),
    .global_rst     (global_rst),
    .pps_refclk     (pps_refclk),
    .seconds        (seconds),
    .last_pps_ticks (last_pps_ticks),
    .pps_seen       (pps_seen)
  );

  // ----------------------------------------
  // Lock filter, clk156 domain
  // ----------------------------------------

  // Raw lock is not trusted as a clean level
  lock_filter lock_filt (
    .clk156        (clk156),
    .global_rst    (global_rst),
    .locked_raw    (locked_raw),
    .clocks_locked (clocks_locked)
  );

endmodule

//--- hdl/pps_timekeeper.sv
`timescale 1ns/100ps

module pps_timekeeper import clocking_pkg::*; (
  input  logic                  ref_clk,
  input  logic                  global_rst,
  // Selected PPS, already in ref_clk
  input  logic                  pps_refclk,
  // Seconds since reset
  output logic [sec_width-1:0]  seconds,
  // ref_clk cycles between the last two detected edges
  output logic [tick_width-1:0] last_pps_ticks,
  // One cycle pulse after each detected edge
  output logic                  pps_seen
);

  logic                  pps_d;
  logic                  pps_rise;
  logic [tick_width-1:0] tick_count;

  // ----------------------------------------
  // Edge detect
  // ----------------------------------------

  // Previous sample of the PPS level
  always_ff @(posedge ref_clk or posedge global_rst) begin
    if (global_rst) begin
      pps_d <= 1'b0;
    end else begin
      pps_d <= pps_refclk;
    end
  end

  // High now and low on the previous edge
  assign pps_rise = pps_refclk & ~pps_d;

  // ----------------------------------------
  // Tick counter
  // ----------------------------------------

  // Free running, restarts at 1 on the detected edge
  // So at the next edge it holds the full spacing in cycles
  // Before the first edge it counts cycles since reset
  always_ff @(posedge ref_clk or posedge global_rst) begin
    if (global_rst) begin
      tick_count <= '0;
    end else if (pps_rise) begin
      tick_count <= tick_width'(1);
    end else begin
      // Wraps silently if the PPS goes missing for a long time
      tick_count <= tick_count + 1'b1;
    end
  end

  // ----------------------------------------
  // Seconds and period capture
  // ----------------------------------------

  // All three outputs change on the cycle after the detected edge
  always_ff @(posedge ref_clk or posedge global_rst) begin
    if (global_rst) begin
      seconds        <= '0;
      last_pps_ticks <= '0;
      pps_seen       <= 1'b0;
    end else begin
      pps_seen <= pps_rise;
      if (pps_rise) begin
        seconds        <= seconds + 1'b1;
        last_pps_ticks <= tick_count;
      end
    end
  end

endmodule

//--- hdl/lock_filter.sv
`timescale 1ns/100ps

module lock_filter import clocking_pkg::*; (
  input  logic clk156,
  input  logic global_rst,
  // Raw lock from the clock synthesizer, may chatter
  input  logic locked_raw,
  // Clean lock, only after a full uninterrupted hold
  output logic clocks_locked
);

  // Reload value of the hold counter
  localparam logic [lock_count_width-1:0] hold_reload =
    lock_hold_cycles[lock_count_width-1:0];

  logic                        locked_sync;
  logic [lock_count_width-1:0] locked_count;

  // ----------------------------------------
  // Capture into clk156
  // ----------------------------------------

  // Lock level, synchronizer clocked by clk156
  synchronizer #(
    .width(1)
  ) lock_sync (
    .clk156     (clk156),
    .global_rst (global_rst),
    .in_data    (locked_raw),
    .out_data   (locked_sync)
  );

  // ----------------------------------------
  // Hold filter
  // ----------------------------------------

  // Any low sample reloads the counter and drops the output
  // Counter walks down while the lock stays high
  // Output only rises once the counter has reached zero
  always_ff @(posedge clk156 or posedge global_rst) begin
    if (global_rst) begin
      locked_count  <= hold_reload;
      clocks_locked <= 1'b0;
    end else if (!locked_sync) begin
      locked_count  <= hold_reload;
      clocks_locked <= 1'b0;
    end else if (locked_count == '0) begin
      // Full hold seen, stay locked until the next low sample
      clocks_locked <= 1'b1;
    end else begin
      locked_count  <= locked_count - 1'b1;
      clocks_locked <= 1'b0;
    end
  end

endmodule

//--- hdl/pps_capture_select.sv
`timescale 1ns/100ps

module pps_capture_select import clocking_pkg::*; (
  input  logic                     ref_clk,
  input  logic                     global_rst,
  // Back panel PPS, asynchronous
  input  logic                     ext_pps_from_pin,
  // GPSDO PPS, asynchronous
  input  logic                     gps_pps_from_pin,
  // One-hot source select, from a slow control domain
  input  logic [pps_sel_width-1:0] pps_select,
  // Selected PPS, registered in ref_clk
  output logic                     pps_refclk
);

  logic                     pps_ext_refclk;
  logic                     pps_gps_refclk;
  logic [pps_sel_width-1:0] pps_select_refclk;

  // ----------------------------------------
  // Capture into ref_clk
  // ----------------------------------------

  // Back panel PPS, synchronizer clocked by ref_clk
  synchronizer #(
    .width(1)
  ) ext_pps_dsync (
    .clk156     (ref_clk),
    .global_rst (global_rst),
    .in_data    (ext_pps_from_pin),
    .out_data   (pps_ext_refclk)
  );

  // GPSDO PPS, synchronizer clocked by ref_clk
  synchronizer #(
    .width(1)
  ) gps_pps_dsync (
    .clk156     (ref_clk),
    .global_rst (global_rst),
    .in_data    (gps_pps_from_pin),
    .out_data   (pps_gps_refclk)
  );

  // Select vector, synchronizer clocked by ref_clk
  // Bits may land on different edges during a change
  synchronizer #(
    .width(pps_sel_width)
  ) pps_select_dsync (
    .clk156     (ref_clk),
    .global_rst (global_rst),
    .in_data    (pps_select),
    .out_data   (pps_select_refclk)
  );

  // ----------------------------------------
  // Priority mux
  // ----------------------------------------

  // Internal bit beats external bit, nothing set falls back to GPSDO
  // A mixed select during a change still picks exactly one source
  // Switchover is asynchronous to the pulse, so a glitch here is expected
  always_ff @(posedge ref_clk or posedge global_rst) begin
    if (global_rst) begin
      pps_refclk <= 1'b0;
    end else if (pps_select_refclk[bit_pps_sel_int]) begin
      pps_refclk <= pps_gps_refclk;
    end else if (pps_select_refclk[bit_pps_sel_ext]) begin
      pps_refclk <= pps_ext_refclk;
    end else begin
      pps_refclk <= pps_gps_refclk;
    end
  end

endmodule

//--- hdl/synchronizer.sv
`timescale 1ns/100ps

module synchronizer import clocking_pkg::*; #(
  // Number of bits carried side by side
  parameter int width = 1
) (
  // Destination clock, whichever domain this instance lives in
  input  logic             clk156,
  input  logic             global_rst,
  input  logic [width-1:0] in_data,
  output logic [width-1:0] out_data
);

  // Flop chain, stage 0 is the metastable capture flop
  logic [width-1:0] stage [sync_stages];

  // Each bit resolves on its own
  // A vector may show a mixed value for one cycle while it changes
  always_ff @(posedge clk156 or posedge global_rst) begin
    if (global_rst) begin
      for (int i = 0; i < sync_stages; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= in_data;
      for (int i = 1; i < sync_stages; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // Last stage is safe to use in the destination domain
  assign out_data = stage[sync_stages-1];

endmodule

//--- hdl/clocking_pkg.sv
package clocking_pkg;

  // ----------------------------------------
  // PPS selection
  // ----------------------------------------

  // Width of the PPS select vector
  localparam int pps_sel_width = 2;

  // Select bit for the internal / GPSDO source
  localparam int bit_pps_sel_int = 0;
  // Select bit for the back panel source
  localparam int bit_pps_sel_ext = 1;

  // ----------------------------------------
  // Lock filter
  // ----------------------------------------

  // Hold counter width
  localparam int lock_count_width = 10;
  // Consecutive locked cycles required, all ones of the counter
  localparam int lock_hold_cycles = (1 << lock_count_width) - 1;

  // ----------------------------------------
  // Timekeeping and synchronizers
  // ----------------------------------------

  localparam int tick_width  = 32;
  localparam int sec_width   = 32;
  // Flop stages in every synchronizer
  localparam int sync_stages = 2;

endpackage
